//--- Bender.yml
package:
  name: array_heap

sources:
  - files:
      - source/heapPkg.sv
      - source/handleAllocator.sv
      - source/arrayLengthTable.sv
      - source/requestChecker.sv
      - source/elementStore.sv
      - source/arrayHeap.sv
  - target: test
    include_dirs:
      - sim
    files:
      - sim/arrayHeapTb.sv

//--- sim/heapRefModel.svh
/*
  Array heap reference model
  Handles, lengths and elements, updated in request order with expected responses
*/
`ifndef HEAP_REF_MODEL_SVH
`define HEAP_REF_MODEL_SVH

logic [heapPkg::Arrays-1:0]   modelLive;                  // Live bit per handle
int                           modelFresh;                 // Handles ever issued
int                           modelFreeStack [$];         // Freed handles, newest at back
int                           modelLength [heapPkg::Arrays];
logic [heapPkg::DataBits-1:0] modelElement [heapPkg::Arrays][heapPkg::ArrayLength];

task automatic initModel();
  modelLive  = '0;
  modelFresh = 0;
  modelFreeStack.delete();
  for (int a = 0; a < heapPkg::Arrays; a++) begin
    modelLength[a] = 0;
    for (int i = 0; i < heapPkg::ArrayLength; i++) begin
      modelElement[a][i] = '0;                             // Filled by the directed writes
    end
  end
endtask

// Applies one accepted request and returns the response it must produce
task automatic applyModel(input heapPkg::heapRequest_t req,
                          output heapPkg::heapResponse_t exp);
  int                           a;
  int                           idx;
  int                           len;
  int                           handle;
  logic [heapPkg::DataBits-1:0] oldValue;
  logic [heapPkg::DataBits-1:0] newValue;
  a           = req.array;
  idx         = req.index;
  len         = modelLength[a];
  exp         = '0;                                        // Errors carry a zero payload
  exp.op      = req.op;
  exp.error   = heapPkg::errNone;
  if (req.op != heapPkg::opAlloc && a >= modelFresh) begin
    exp.error = heapPkg::errNotAllocated;
  end else if (req.op != heapPkg::opAlloc && !modelLive[a]) begin
    exp.error = heapPkg::errFreed;
  end else begin
    case (req.op)
      heapPkg::opAlloc:
        if (modelFreeStack.size() == 0 && modelFresh == heapPkg::Arrays) begin
          exp.error = heapPkg::errOutOfMemory;
        end else begin
          if (modelFreeStack.size() != 0) handle = modelFreeStack.pop_back();  // Newest free
          else handle = modelFresh++;
          modelLive[handle]          = 1'b1;
          modelLength[handle]        = 0;
          exp.payload.handle.value   = heapPkg::ArrayBits'(handle);
        end
      heapPkg::opFree: begin
        modelLive[a] = 1'b0;
        modelFreeStack.push_back(a);
      end
      heapPkg::opWrite: begin
        modelElement[a][idx] = req.operand;
        if (idx + 1 > len) modelLength[a] = idx + 1;       // Extends the array
        exp.payload.element  = req.operand;
      end
      heapPkg::opSize:
        exp.payload.count.value = heapPkg::LengthBits'(len);
      heapPkg::opResize:
        if (req.operand > heapPkg::ArrayLength) exp.error = heapPkg::errTooLarge;
        else modelLength[a] = req.operand;
      heapPkg::opPush:
        if (len == heapPkg::ArrayLength) begin
          exp.error = heapPkg::errFull;
        end else begin
          modelElement[a][len] = req.operand;
          modelLength[a]       = len + 1;
          exp.payload.element  = req.operand;
        end
      heapPkg::opPop:
        if (len == 0) begin
          exp.error = heapPkg::errEmpty;
        end else begin
          modelLength[a]      = len - 1;
          exp.payload.element = modelElement[a][len - 1];
        end
      default:                                             // Read and arithmetic
        if (idx >= len) begin
          exp.error = heapPkg::errOutOfBounds;
        end else begin
          oldValue = modelElement[a][idx];
          case (req.op)
            heapPkg::opAdd, heapPkg::opAddAfter: newValue = oldValue + req.operand;
            heapPkg::opSub, heapPkg::opSubAfter: newValue = oldValue - req.operand;
            heapPkg::opOr:                       newValue = oldValue | req.operand;
            heapPkg::opXor:                      newValue = oldValue ^ req.operand;
            heapPkg::opAnd:                      newValue = oldValue & req.operand;
            default:                             newValue = oldValue;   // Read
          endcase
          modelElement[a][idx] = newValue;
          if (req.op inside {heapPkg::opAddAfter, heapPkg::opSubAfter}) begin
            exp.payload.element = oldValue;
          end else begin
            exp.payload.element = newValue;
          end
        end
    endcase
  end
endtask

`endif

//--- sim/arrayHeapTb.sv
/*
  Array heap testbench
  Directed fill, then LFSR-driven requests checked against the reference model
*/
`default_nettype none

module arrayHeapTb;
  timeunit 1ns;
  timeprecision 1ps;

  localparam int ResetCycles   = 8;
  localparam int DirectedSlots = 1 + heapPkg::Arrays + 1 + heapPkg::Arrays * heapPkg::ArrayLength;
  localparam int RandomSlots   = 400;
  localparam int EarlySlots    = 120;                     // Alloc, Write, Push favored
  localparam int DrainSlots    = 3;
  localparam int CycleLimit    = ResetCycles + DirectedSlots + RandomSlots + DrainSlots + 20;

  logic                   clock;
  logic                   resetN;
  logic                   requestValid;
  heapPkg::heapRequest_t  request;
  logic                   responseValid;
  heapPkg::heapResponse_t response;
  logic [31:0]            lfsrState;
  int                     checksFailed;
  int                     cycleCount = 0;
  logic                   expectedValid [$];              // One entry per driven slot
  heapPkg::heapResponse_t expectedResponse [$];

  `include "heapRefModel.svh"

  arrayHeap u_dut (
    .clock, .resetN, .requestValid, .request, .responseValid, .response
  );

  initial clock = 1'b0;
  always #20 clock = ~clock;                              // 40 ns period

  always @(posedge clock) begin
    cycleCount <= cycleCount + 1;
    if (cycleCount >= CycleLimit) begin
      $display("Some tests failed");
      $fatal(1, "Timeout: run still going after %0d cycles", cycleCount);
    end
  end

  // ------------------------------------------------
  // Random numbers and checks
  // ------------------------------------------------
  function automatic logic [31:0] lfsrNext(input logic [31:0] state);
    return {state[30:0], state[31] ^ state[21] ^ state[1] ^ state[0]};  // Taps 32 22 2 1
  endfunction

  task automatic randomBits(input int count, output logic [31:0] bits);
    bits = '0;
    for (int i = 0; i < count; i++) begin
      lfsrState = lfsrNext(lfsrState);
      bits      = {bits[30:0], lfsrState[0]};            // One step per bit
    end
  endtask

  task automatic checkValue(input string name, input logic [31:0] actual,
                            input logic [31:0] expected);
    if (actual !== expected) begin
      checksFailed++;
      $display("MISMATCH %s: got %h, expected %h", name, actual, expected);
      $display("Some tests failed");
      $fatal(1, "Stopped at the first wrong value");
    end
  endtask

  // Response seen now belongs to the slot driven two falling edges ago
  task automatic checkResponse();
    logic                   wantValid;
    heapPkg::heapResponse_t want;
    wantValid = 1'b0;
    want      = '0;
    if (expectedValid.size() == 2) begin
      wantValid = expectedValid.pop_front();
      want      = expectedResponse.pop_front();
    end
    checkValue("responseValid", responseValid, wantValid);
    if (wantValid) begin
      checkValue("response.op", response.op, want.op);
      checkValue("response.error", response.error, want.error);
      checkValue("response.payload", response.payload, want.payload);
    end
  endtask

  task automatic runSlot(input logic valid, input heapPkg::heapRequest_t req);
    heapPkg::heapResponse_t exp;
    @(negedge clock);
    checkResponse();
    exp = '0;
    if (valid) applyModel(req, exp);
    expectedValid.push_back(valid);
    expectedResponse.push_back(exp);
    requestValid = valid;
    request      = valid ? req : '0;
  endtask

  task automatic makeRequest(input logic early, output logic valid,
                             output heapPkg::heapRequest_t req);
    logic [31:0] bits;
    req = '0;
    randomBits(3, bits);
    valid = (bits[2:0] != 3'd0);                          // About one idle slot in eight
    randomBits(2, bits);
    if (early && bits[1:0] != 2'd3) begin
      randomBits(2, bits);
      case (bits[1:0])
        2'd0:    req.op = heapPkg::opAlloc;
        2'd1:    req.op = heapPkg::opPush;
        default: req.op = heapPkg::opWrite;
      endcase
    end else begin
      randomBits(4, bits);
      req.op = heapPkg::heapOp_t'({1'b0, bits[3:0]} % 5'd15);
    end
    randomBits(heapPkg::ArrayBits, bits);
    req.array = bits[heapPkg::ArrayBits-1:0];
    randomBits(heapPkg::IndexBits, bits);
    req.index = bits[heapPkg::IndexBits-1:0];
    if (req.op == heapPkg::opResize) begin
      randomBits(3, bits);                                // Sometimes past ArrayLength
      req.operand = heapPkg::DataBits'(bits[2:0]);
    end else begin
      randomBits(heapPkg::DataBits, bits);
      req.operand = bits[heapPkg::DataBits-1:0];
    end
  endtask

  // ------------------------------------------------
  // Stimulus
  // ------------------------------------------------
  initial begin
    heapPkg::heapRequest_t req;
    logic [31:0]           bits;
    logic                  valid;
    resetN       = 1'b0;
    requestValid = 1'b0;
    request      = '0;
    lfsrState    = 32'h668e;
    checksFailed = 0;
    initModel();
    repeat (ResetCycles) begin
      @(negedge clock);
      checkValue("responseValid", responseValid, 1'b0);   // Quiet during reset
    end
    resetN = 1'b1;

    req       = '0;
    req.op    = heapPkg::opRead;
    req.array = 2'd3;                                     // Not yet issued
    runSlot(1'b1, req);
    repeat (heapPkg::Arrays + 1) begin
      req    = '0;
      req.op = heapPkg::opAlloc;                          // Last one runs out
      runSlot(1'b1, req);
    end
    // Every element gets a known value, lengths grow to the maximum
    for (int a = 0; a < heapPkg::Arrays; a++) begin
      for (int i = 0; i < heapPkg::ArrayLength; i++) begin
        randomBits(heapPkg::DataBits, bits);
        req         = '0;
        req.op      = heapPkg::opWrite;
        req.array   = heapPkg::ArrayBits'(a);
        req.index   = heapPkg::IndexBits'(i);
        req.operand = bits[heapPkg::DataBits-1:0];
        runSlot(1'b1, req);
      end
    end

    for (int slot = 0; slot < RandomSlots; slot++) begin
      makeRequest(slot < EarlySlots, valid, req);
      runSlot(valid, req);
    end
    repeat (DrainSlots) runSlot(1'b0, '0);

    if (checksFailed == 0) begin
      $display("All tests passed");
    end else begin
      $display("Some tests failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- source/arrayHeap.sv
/*
  Array heap top level
  Two-stage pipeline with fixed two-cycle latency and no back-pressure
*/
`default_nettype none

module arrayHeap (
  input  logic                   clock,
  input  logic                   resetN,
  input  logic                   requestValid,
  input  heapPkg::heapRequest_t  request,
  output logic                   responseValid,
  output heapPkg::heapResponse_t response
);

  logic [heapPkg::Arrays-1:0]                           live;
  logic [heapPkg::LengthBits-1:0]                       freshCount;
  logic [heapPkg::ArrayBits-1:0]                        nextHandle;
  logic                                                 exhausted;
  logic [heapPkg::Arrays-1:0][heapPkg::LengthBits-1:0]  lengths;
  logic                                                 allocate;
  logic                                                 releaseStrobe;
  logic [heapPkg::ArrayBits-1:0]                        releaseHandle;
  logic                                                 lengthWrite;
  logic [heapPkg::ArrayBits-1:0]                        lengthArray;
  logic [heapPkg::LengthBits-1:0]                       lengthValue;
  heapPkg::heapCommand_t                                command;    // Stage 1 to stage 2

  handleAllocator handles (
    .clock, .resetN, .allocate, .releaseStrobe, .releaseHandle,
    .live, .freshCount, .nextHandle, .exhausted
  );

  arrayLengthTable lengthTable (
    .clock, .resetN, .lengthWrite, .lengthArray, .lengthValue, .lengths
  );

  requestChecker validator (
    .clock, .resetN, .requestValid, .request,
    .live, .freshCount, .nextHandle, .exhausted, .lengths,
    .allocate, .releaseStrobe, .releaseHandle,
    .lengthWrite, .lengthArray, .lengthValue, .command
  );

  elementStore store (
    .clock, .resetN, .command, .responseValid, .response
  );

endmodule

`default_nettype wire

//--- source/arrayLengthTable.sv
/*
  Array length table
  Current length of every array, loaded on a write strobe
*/
`default_nettype none

module arrayLengthTable (
  input  logic                                              clock,
  input  logic                                              resetN,
  input  logic                                              lengthWrite,
  input  logic [heapPkg::ArrayBits-1:0]                     lengthArray,
  input  logic [heapPkg::LengthBits-1:0]                    lengthValue,
  output logic [heapPkg::Arrays-1:0][heapPkg::LengthBits-1:0] lengths
);

  always_ff @(posedge clock or negedge resetN) begin
    if (!resetN) begin
      lengths <= '0;                             // Every array empty
    end else if (lengthWrite) begin
      lengths[lengthArray] <= lengthValue;
    end
  end

  // Keeps stage 2 slots inside the element block
  assert property (@(posedge clock) disable iff (!resetN)
                   lengthWrite |-> lengthValue <= heapPkg::ArrayLength)
    else $error("length %0d written to array %0d", lengthValue, lengthArray);

endmodule

`default_nettype wire

//--- source/elementStore.sv
/*
  Stage 2 element store
  Element storage, element arithmetic and the response register
*/
`default_nettype none

module elementStore (
  input  logic                  clock,
  input  logic                  resetN,
  input  heapPkg::heapCommand_t command,
  output logic                  responseValid,
  output heapPkg::heapResponse_t response
);

  // Arrays by ArrayLength elements
  logic [heapPkg::Arrays-1:0][heapPkg::ArrayLength-1:0][heapPkg::DataBits-1:0] elements;
  logic [heapPkg::DataBits-1:0] oldValue;
  logic [heapPkg::DataBits-1:0] newValue;
  logic                         writeElement;
  heapPkg::heapPayload_t        result;

  // ------------------------------------------------
  // Element operation
  // ------------------------------------------------
  always_comb begin
    oldValue     = elements[command.array][command.slot];
    newValue     = command.operand;
    writeElement = 1'b0;
    result       = command.payload;              // Alloc, Free, Size, Resize, errors
    if (command.valid && command.error == heapPkg::errNone) begin
      case (command.op)
        heapPkg::opWrite, heapPkg::opPush: begin
          writeElement   = 1'b1;
          result.element = command.operand;
        end
        heapPkg::opRead, heapPkg::opPop:
          result.element = oldValue;
        heapPkg::opAdd, heapPkg::opAddAfter: begin
          writeElement = 1'b1;
          newValue     = oldValue + command.operand;    // Wraps at DataBits
        end
        heapPkg::opSub, heapPkg::opSubAfter: begin
          writeElement = 1'b1;
          newValue     = oldValue - command.operand;
        end
        heapPkg::opOr: begin
          writeElement = 1'b1;
          newValue     = oldValue | command.operand;
        end
        heapPkg::opXor: begin
          writeElement = 1'b1;
          newValue     = oldValue ^ command.operand;
        end
        heapPkg::opAnd: begin
          writeElement = 1'b1;
          newValue     = oldValue & command.operand;
        end
        default: ;
      endcase
      // Arithmetic answers with the new value, After forms with the old one
      if (command.op inside {heapPkg::opAdd, heapPkg::opSub, heapPkg::opOr,
                             heapPkg::opXor, heapPkg::opAnd}) begin
        result.element = newValue;
      end else if (command.op inside {heapPkg::opAddAfter, heapPkg::opSubAfter}) begin
        result.element = oldValue;
      end
    end
  end

  always_ff @(posedge clock) begin
    if (writeElement) begin
      elements[command.array][command.slot] <= newValue;
    end
  end

  // ------------------------------------------------
  // Response register
  // ------------------------------------------------
  always_ff @(posedge clock or negedge resetN) begin
    if (!resetN) begin
      responseValid <= 1'b0;
    end else begin
      responseValid    <= command.valid;
      response.op      <= command.op;
      response.error   <= command.error;
      response.payload <= result;
    end
  end

  // A rejected request leaves the whole store untouched
  assert property (@(posedge clock) disable iff (!resetN)
                   command.valid && command.error != heapPkg::errNone |=> $stable(elements))
    else $error("element changed by a rejected command");

endmodule

`default_nettype wire

//--- source/handleAllocator.sv
/*
  Handle allocator
  Hands out recently freed handles first, then fresh ones, and keeps live bits
*/
`default_nettype none

module handleAllocator (
  input  logic                             clock,
  input  logic                             resetN,
  input  logic                             allocate,       // Take nextHandle
  input  logic                             releaseStrobe,  // Return releaseHandle
  input  logic [heapPkg::ArrayBits-1:0]    releaseHandle,
  output logic [heapPkg::Arrays-1:0]       live,           // One bit per handle
  output logic [heapPkg::LengthBits-1:0]   freshCount,     // Handles ever issued
  output logic [heapPkg::ArrayBits-1:0]    nextHandle,
  output logic                             exhausted
);

  logic [heapPkg::ArrayBits-1:0]  freeStack [heapPkg::Arrays];  // LIFO of freed handles
  logic [heapPkg::LengthBits-1:0] stackDepth;
  logic [heapPkg::ArrayBits-1:0]  stackTop;

  assign stackTop   = freeStack[stackDepth[heapPkg::ArrayBits-1:0] - 1'b1];
  assign nextHandle = (stackDepth != '0) ? stackTop
                                         : freshCount[heapPkg::ArrayBits-1:0];
  assign exhausted  = (stackDepth == '0) && (freshCount == heapPkg::Arrays);

  // ------------------------------------------------
  // Depth, fresh counter and live bits
  // ------------------------------------------------
  always_ff @(posedge clock or negedge resetN) begin
    if (!resetN) begin
      stackDepth <= '0;
      freshCount <= '0;
      live       <= '0;                        // All handles free
    end else if (allocate) begin
      if (stackDepth != '0) begin
        stackDepth <= stackDepth - 1'b1;       // Reuse freed handle
      end else begin
        freshCount <= freshCount + 1'b1;       // Issue fresh handle
      end
      live[nextHandle] <= 1'b1;
    end else if (releaseStrobe) begin
      stackDepth          <= stackDepth + 1'b1;
      live[releaseHandle] <= 1'b0;             // Clear the freed handle itself
    end
  end

  always_ff @(posedge clock) begin
    if (releaseStrobe) begin
      freeStack[stackDepth[heapPkg::ArrayBits-1:0]] <= releaseHandle;
    end
  end

  // Stage 1 must turn these into errors before they reach here
  assert property (@(posedge clock) disable iff (!resetN) allocate |-> !exhausted)
    else $error("allocate while exhausted");
  assert property (@(posedge clock) disable iff (!resetN)
                   releaseStrobe |-> live[releaseHandle])
    else $error("release of handle %0d that is not live", releaseHandle);

endmodule

`default_nettype wire

//--- source/heapPkg.sv
/*
  Array heap definitions
  Sizes, opcodes, error codes and the request, command and response words
*/
`default_nettype none

package heapPkg;

  // ------------------------------------------------
  // Sizes
  // ------------------------------------------------
  localparam int ArrayBits   = 2;               // Handle width
  localparam int IndexBits   = 2;               // Element index width
  localparam int DataBits    = 12;              // Element width
  localparam int Arrays      = 4;               // Handles available
  localparam int ArrayLength = 4;               // Max elements per array
  localparam int LengthBits  = IndexBits + 1;   // Holds 0 to ArrayLength

  // ------------------------------------------------
  // Opcodes and errors
  // ------------------------------------------------
  typedef enum logic [4:0] {
    opAlloc,      // New handle
    opFree,       // Return handle
    opWrite,      // Store, may extend length
    opRead,       // Fetch element
    opSize,       // Current length
    opResize,     // Set length
    opPush,       // Store at end
    opPop,        // Remove from end
    opAdd,        // New value returned
    opAddAfter,   // Old value returned
    opSub,
    opSubAfter,
    opOr,
    opXor,
    opAnd
  } heapOp_t;

  typedef enum logic [2:0] {
    errNone,
    errNotAllocated,  // Handle never issued
    errFreed,         // Handle not live
    errOutOfBounds,   // Index at or past length
    errFull,          // Push at max length
    errEmpty,         // Pop at zero length
    errOutOfMemory,   // No handle left
    errTooLarge       // Resize past max length
  } heapError_t;

  // ------------------------------------------------
  // Request, command and response words
  // ------------------------------------------------
  typedef struct packed {
    heapOp_t               op;
    logic [ArrayBits-1:0]  array;
    logic [IndexBits-1:0]  index;
    logic [DataBits-1:0]   operand;
  } heapRequest_t;

  // One response word, read as data, handle or length
  typedef union packed {
    logic [DataBits-1:0] element;
    struct packed {
      logic [DataBits-ArrayBits-1:0] zero;
      logic [ArrayBits-1:0]          value;
    } handle;
    struct packed {
      logic [DataBits-LengthBits-1:0] zero;
      logic [LengthBits-1:0]          value;
    } count;
  } heapPayload_t;

  typedef struct packed {
    logic                  valid;
    heapOp_t               op;
    logic [ArrayBits-1:0]  array;
    logic [IndexBits-1:0]  slot;      // Element touched in stage 2
    logic [DataBits-1:0]   operand;
    heapError_t            error;
    heapPayload_t          payload;   // Ready answer for storage-free ops
  } heapCommand_t;

  typedef struct packed {
    heapOp_t      op;
    heapError_t   error;
    heapPayload_t payload;
  } heapResponse_t;

endpackage

`default_nettype wire

//--- source/requestChecker.sv
/*
  Stage 1 request checker
  Validates each request, updates handle and length state, registers a command
*/
`default_nettype none

module requestChecker (
  input  logic                                              clock,
  input  logic                                              resetN,
  input  logic                                              requestValid,
  input  heapPkg::heapRequest_t                             request,
  input  logic [heapPkg::Arrays-1:0]                        live,
  input  logic [heapPkg::LengthBits-1:0]                    freshCount,
  input  logic [heapPkg::ArrayBits-1:0]                     nextHandle,
  input  logic                                              exhausted,
  input  logic [heapPkg::Arrays-1:0][heapPkg::LengthBits-1:0] lengths,
  output logic                                              allocate,
  output logic                                              releaseStrobe,
  output logic [heapPkg::ArrayBits-1:0]                     releaseHandle,
  output logic                                              lengthWrite,
  output logic [heapPkg::ArrayBits-1:0]                     lengthArray,
  output logic [heapPkg::LengthBits-1:0]                    lengthValue,
  output heapPkg::heapCommand_t                             command
);

  logic [heapPkg::LengthBits-1:0] length;       // Length of addressed array
  logic [heapPkg::LengthBits-1:0] indexEnd;     // Index plus one
  logic [heapPkg::LengthBits-1:0] nextSlot;
  logic                           changeLength;
  logic                           accept;       // Valid and error free
  heapPkg::heapError_t            error;
  heapPkg::heapPayload_t          payload;

  // ------------------------------------------------
  // Checks in rule order
  // ------------------------------------------------
  always_comb begin
    length       = lengths[request.array];
    indexEnd     = heapPkg::LengthBits'(request.index) + 1'b1;
    nextSlot     = heapPkg::LengthBits'(request.index);
    lengthValue  = length;
    changeLength = 1'b0;
    error        = heapPkg::errNone;
    payload      = '0;
    if (request.op != heapPkg::opAlloc && request.array >= freshCount) begin
      error = heapPkg::errNotAllocated;
    end else if (request.op != heapPkg::opAlloc && !live[request.array]) begin
      error = heapPkg::errFreed;
    end else begin
      case (request.op)
        heapPkg::opAlloc:
          if (exhausted) error = heapPkg::errOutOfMemory;
          else begin
            changeLength               = 1'b1;      // New array starts empty
            lengthValue                = '0;
            payload.handle.value       = nextHandle;
          end
        heapPkg::opWrite:
          if (indexEnd > length) begin
            changeLength = 1'b1;                    // Write extends the array
            lengthValue  = indexEnd;
          end
        heapPkg::opSize:
          payload.count.value = length;
        heapPkg::opResize:
          if (request.operand > heapPkg::ArrayLength) error = heapPkg::errTooLarge;
          else begin
            changeLength = 1'b1;
            lengthValue  = request.operand[heapPkg::LengthBits-1:0];
          end
        heapPkg::opPush:
          if (length == heapPkg::ArrayLength) error = heapPkg::errFull;
          else begin
            nextSlot     = length;                  // Store at the end
            changeLength = 1'b1;
            lengthValue  = length + 1'b1;
          end
        heapPkg::opPop:
          if (length == '0) error = heapPkg::errEmpty;
          else begin
            nextSlot     = length - 1'b1;           // Last element
            changeLength = 1'b1;
            lengthValue  = length - 1'b1;
          end
        heapPkg::opFree: ;
        default:                                    // Read and arithmetic
          if (indexEnd > length) error = heapPkg::errOutOfBounds;
      endcase
    end
  end

  // ------------------------------------------------
  // State strobes
  // ------------------------------------------------
  assign accept        = requestValid && (error == heapPkg::errNone);
  assign allocate      = accept && (request.op == heapPkg::opAlloc);
  assign releaseStrobe = accept && (request.op == heapPkg::opFree);
  assign releaseHandle = request.array;
  assign lengthWrite   = accept && changeLength;
  assign lengthArray   = (request.op == heapPkg::opAlloc) ? nextHandle : request.array;

  always_ff @(posedge clock or negedge resetN) begin
    if (!resetN) begin
      command.valid <= 1'b0;
    end else begin
      command.valid   <= requestValid;
      command.op      <= request.op;
      command.array   <= request.array;
      command.slot    <= nextSlot[heapPkg::IndexBits-1:0];
      command.operand <= request.operand;
      command.error   <= error;
      command.payload <= payload;
    end
  end

  // Length table and checks together keep push and pop slots in range
  assert property (@(posedge clock) disable iff (!resetN)
                   accept |-> nextSlot < heapPkg::ArrayLength)
    else $error("slot %0d out of range for op %s", nextSlot, request.op.name());

endmodule

`default_nettype wire

//--- vlog.f
+incdir+sim
source/heapPkg.sv
source/handleAllocator.sv
source/arrayLengthTable.sv
source/requestChecker.sv
source/elementStore.sv
source/arrayHeap.sv
sim/arrayHeapTb.sv
